//--- Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - hdl/rob_pkg.sv
  - files:
      - hdl/dispatch_decode.sv
      - hdl/exec_alu.sv
      - hdl/exec_mul.sv
      - hdl/reorder_buffer.sv
      - hdl/commit_writeback.sv
      - hdl/ooo_core_top.sv
  - target: simulation
    files:
      - verification/tb_ooo_core.sv

//--- all.f
hdl/rob_pkg.sv
hdl/dispatch_decode.sv
hdl/exec_alu.sv
hdl/exec_mul.sv
hdl/reorder_buffer.sv
hdl/commit_writeback.sv
hdl/ooo_core_top.sv
verification/tb_ooo_core.sv

//--- hdl/commit_writeback.sv
`default_nettype none

module commit_writeback import rob_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      commit_in_valid,
    input  wire commit_t   commit_in,         // Retirement from the buffer
    input  wire reg_addr_t rd_addr,           // Debug read port
    output logic           commit_valid,
    output commit_t        commit,
    output data_t          rd_data
);

    data_t regs [32];                         // Architectural register file

    assign rd_data = regs[rd_addr];           // Combinational read

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;                // Architectural state starts at zero
            end
        end else if (commit_in_valid) begin
            regs[commit_in.rd] <= commit_in.value; // R0 is an ordinary register
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_in_valid;  // One cycle behind the buffer
        end
    end

    always_ff @(posedge clk) begin
        if (commit_in_valid) begin
            commit <= commit_in;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dispatch_decode.sv
`default_nettype none

module dispatch_decode import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8                   // Credits after reset
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire instr_t   in_instr,
    input  wire rob_tag_t alloc_tag,              // Tail tag from the buffer
    input  wire logic     alloc_epoch,            // Current buffer epoch
    input  wire logic     credit_valid,
    input  wire cnt_t     credit_count,           // Entries freed by retire or squash
    input  wire logic     squash_valid,
    output logic          in_ready,
    output logic          alloc_valid,
    output reg_addr_t     alloc_rd,
    output logic          alu_issue_valid,
    output issue_t        alu_issue,
    output logic          mul_issue_valid,
    output issue_t        mul_issue
);

    cnt_t   credits;                              // Free buffer entries as seen here
    logic   accept;                               // Instruction transfer this cycle
    logic   is_mul;                               // Steers to the multiplier path
    issue_t issue_d;                              // Packet built from the input

    assign in_ready    = (credits != '0) && !squash_valid; // Squash blocks allocation
    assign accept      = in_valid && in_ready;
    assign is_mul      = in_instr.op == OP_MUL;
    assign alloc_valid = accept;                  // Buffer writes the entry on this edge
    assign alloc_rd    = in_instr.rd;

    assign issue_d = '{op: in_instr.op, tag: alloc_tag, epoch: alloc_epoch,
                       a: in_instr.a, b: in_instr.b};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits         <= cnt_t'(ROB_DEPTH); // Buffer starts empty
            alu_issue_valid <= 1'b0;
            mul_issue_valid <= 1'b0;
        end else begin
            credits         <= credits + (credit_valid ? credit_count : '0) - cnt_t'(accept);
            alu_issue_valid <= accept && !is_mul;
            mul_issue_valid <= accept && is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_mul) alu_issue <= issue_d;
        if (accept && is_mul) mul_issue <= issue_d;
    end

    // Credits must track buffer occupancy; an underflow wraps above ROB_DEPTH too
    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        credits <= cnt_t'(ROB_DEPTH));

endmodule

`default_nettype wire

//--- hdl/exec_alu.sv
`default_nettype none

module exec_alu import rob_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   issue_valid,
    input  wire issue_t issue,
    output logic        result_valid,
    output result_t     result
);

    data_t value;                                 // Combinational ALU output

    always_comb begin
        case (issue.op)
            OP_ADD:  value = issue.a + issue.b;
            OP_SUB:  value = issue.a - issue.b;
            OP_XOR:  value = issue.a ^ issue.b;
            OP_AND:  value = issue.a & issue.b;
            default: value = '0;                  // Mul never lands here
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;          // One cycle, no back-pressure
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result.tag   <= issue.tag;            // Tag and epoch ride along
            result.epoch <= issue.epoch;
            result.value <= value;
        end
    end

    // Dispatch steers every multiply to exec_mul
    a_no_mul: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> issue.op != OP_MUL);

endmodule

`default_nettype wire

//--- hdl/exec_mul.sv
`default_nettype none

module exec_mul import rob_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   issue_valid,
    input  wire issue_t issue,
    output logic        result_valid,
    output result_t     result
);

    logic    s1_valid;                            // Operand stage
    issue_t  s1;
    logic    s2_valid;                            // Product stage
    result_t s2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= issue_valid;          // Up to three multiplies in flight
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1 <= issue;                          // Register the operands
        end
        if (s1_valid) begin
            s2.tag   <= s1.tag;
            s2.epoch <= s1.epoch;
            s2.value <= s1.a * s1.b;              // Low 32 bits of the product
        end
        if (s2_valid) begin
            result <= s2;                         // Output register
        end
    end

    // Only multiplies are routed here by dispatch
    a_only_mul: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> issue.op == OP_MUL);

endmodule

`default_nettype wire

//--- hdl/ooo_core_top.sv
`default_nettype none

module ooo_core_top import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_valid,
    input  wire instr_t    in_instr,
    input  wire logic      squash_valid,
    input  wire rob_tag_t  squash_tag,
    input  wire reg_addr_t rd_addr,
    output logic           in_ready,
    output logic           commit_valid,
    output commit_t        commit,
    output data_t          rd_data
);

    logic      alloc_valid;
    reg_addr_t alloc_rd;
    rob_tag_t  alloc_tag;
    logic      alloc_epoch;
    logic      credit_valid;
    cnt_t      credit_count;
    logic      alu_issue_valid;
    issue_t    alu_issue;
    logic      mul_issue_valid;
    issue_t    mul_issue;
    logic      alu_result_valid;
    result_t   alu_result;
    logic      mul_result_valid;
    result_t   mul_result;
    logic      rob_commit_valid;                  // Buffer side of the commit stream
    commit_t   rob_commit;

    dispatch_decode #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
        .clk, .rst, .in_valid, .in_instr, .alloc_tag, .alloc_epoch,
        .credit_valid, .credit_count, .squash_valid, .in_ready, .alloc_valid,
        .alloc_rd, .alu_issue_valid, .alu_issue, .mul_issue_valid, .mul_issue);

    exec_alu u_alu (.clk, .rst, .issue_valid(alu_issue_valid), .issue(alu_issue),
        .result_valid(alu_result_valid), .result(alu_result));

    exec_mul u_mul (.clk, .rst, .issue_valid(mul_issue_valid), .issue(mul_issue),
        .result_valid(mul_result_valid), .result(mul_result));

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst, .alloc_valid, .alloc_rd, .alu_result_valid, .alu_result,
        .mul_result_valid, .mul_result, .squash_valid, .squash_tag, .alloc_tag,
        .alloc_epoch, .credit_valid, .credit_count,
        .commit_valid(rob_commit_valid), .commit(rob_commit));

    commit_writeback u_wb (.clk, .rst, .commit_in_valid(rob_commit_valid),
        .commit_in(rob_commit), .rd_addr, .commit_valid, .commit, .rd_data);

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`default_nettype none

module reorder_buffer import rob_pkg::*; #(
    parameter int ROB_DEPTH = 8                   // Power of two, up to 16
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      alloc_valid,
    input  wire reg_addr_t alloc_rd,
    input  wire logic      alu_result_valid,
    input  wire result_t   alu_result,
    input  wire logic      mul_result_valid,
    input  wire result_t   mul_result,
    input  wire logic      squash_valid,
    input  wire rob_tag_t  squash_tag,            // Last entry that survives
    output rob_tag_t       alloc_tag,
    output logic           alloc_epoch,
    output logic           credit_valid,
    output cnt_t           credit_count,
    output logic           commit_valid,
    output commit_t        commit
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;              // Wraps at ROB_DEPTH
    typedef enum logic {ROB_RUN, ROB_SQUASH} rob_state_e;

    rob_state_e           state;
    ptr_t                 head;                   // Oldest entry
    ptr_t                 tail;                   // Next entry to allocate
    cnt_t                 count;                  // Occupied entries
    logic                 epoch;                  // Toggles on every squash
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] ready;                  // Result has arrived
    logic [ROB_DEPTH-1:0] ent_epoch;
    reg_addr_t            ent_rd [ROB_DEPTH];
    data_t                ent_value [ROB_DEPTH];
    ptr_t                 sq_ptr;
    ptr_t                 alu_idx;
    ptr_t                 mul_idx;
    logic                 alu_hit;                // Result matches a live entry
    logic                 mul_hit;
    cnt_t                 kept;                   // Entries up to and including squash_tag
    logic                 retire;

    // Distance from the head in program order
    function automatic ptr_t age_of(input ptr_t idx);
        return idx - head;
    endfunction

    assign sq_ptr      = squash_tag[PTR_W-1:0];
    assign alu_idx     = alu_result.tag[PTR_W-1:0];
    assign mul_idx     = mul_result.tag[PTR_W-1:0];
    assign alu_hit     = alu_result_valid && busy[alu_idx] &&
                         (ent_epoch[alu_idx] == alu_result.epoch);
    assign mul_hit     = mul_result_valid && busy[mul_idx] &&
                         (ent_epoch[mul_idx] == mul_result.epoch);
    assign kept        = cnt_t'(ptr_t'(sq_ptr - head)) + cnt_t'(1);
    assign retire      = (state == ROB_RUN) && !squash_valid && busy[head] && ready[head];
    assign alloc_tag   = rob_tag_t'(tail);
    assign alloc_epoch = epoch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ROB_RUN;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            epoch        <= 1'b0;
            busy         <= '0;
            ready        <= '0;
            ent_epoch    <= '0;
            credit_valid <= 1'b0;
            credit_count <= '0;
            commit_valid <= 1'b0;
        end else begin
            credit_valid <= retire || squash_valid;
            credit_count <= squash_valid ? count - kept : cnt_t'(1); // Squash returns dropped
            commit_valid <= retire;
            if (alloc_valid && !squash_valid) begin // Squash wins over allocation
                busy[tail]      <= 1'b1;
                ready[tail]     <= 1'b0;
                ent_epoch[tail] <= epoch;
                tail            <= tail + ptr_t'(1);
            end
            if (alu_hit) ready[alu_idx] <= 1'b1;
            if (mul_hit) ready[mul_idx] <= 1'b1;
            if (retire) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + ptr_t'(1);
            end
            if (squash_valid) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (age_of(ptr_t'(i)) > age_of(sq_ptr)) begin
                        busy[i]  <= 1'b0; // Younger than the squash point
                        ready[i] <= 1'b0;
                    end
                end
                tail  <= sq_ptr + ptr_t'(1);       // Roll allocation back
                count <= kept;
                epoch <= ~epoch;                   // In-flight results go stale
                state <= ROB_SQUASH;
            end else begin
                count <= count + cnt_t'(alloc_valid) - cnt_t'(retire);
                state <= ROB_RUN;                  // Retirement resumes after rollback
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid && !squash_valid) ent_rd[tail] <= alloc_rd;
        if (alu_hit) ent_value[alu_idx] <= alu_result.value;
        if (mul_hit) ent_value[mul_idx] <= mul_result.value;
        if (retire) begin
            commit.rd    <= ent_rd[head];
            commit.value <= ent_value[head];
            commit.tag   <= rob_tag_t'(head);
        end
    end

    // Dispatch credits must keep allocation off a full buffer
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> count < cnt_t'(ROB_DEPTH));

    a_squash_live: assert property (@(posedge clk) disable iff (rst)
        squash_valid |-> busy[sq_ptr]);

endmodule

`default_nettype wire

//--- hdl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    localparam int TAG_W  = 4;                    // Tag width for ROB_DEPTH up to 16
    localparam int DATA_W = 32;                   // Operand and result width
    localparam int REG_W  = 5;                    // 32 architectural registers

    typedef logic [DATA_W-1:0] data_t;            // Operand or result word
    typedef logic [REG_W-1:0]  reg_addr_t;        // Architectural register index
    typedef logic [TAG_W-1:0]  rob_tag_t;         // Reorder-buffer entry index
    typedef logic [TAG_W:0]    cnt_t;             // Entry or credit count up to 16

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_AND,
        OP_MUL                                    // Only op routed to the multiplier
    } op_e;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;                            // Destination register
        data_t     a;
        data_t     b;
    } instr_t;                                    // Instruction entering the core

    typedef struct packed {
        op_e      op;
        rob_tag_t tag;                            // Entry the result belongs to
        logic     epoch;                          // Epoch at allocation
        data_t    a;
        data_t    b;
    } issue_t;                                    // Dispatch to execution unit

    typedef struct packed {
        rob_tag_t tag;
        logic     epoch;                          // Stale results fail the epoch match
        data_t    value;
    } result_t;                                   // Execution unit to buffer

    typedef struct packed {
        reg_addr_t rd;
        data_t     value;
        rob_tag_t  tag;                           // Retired entry
    } commit_t;                                   // Buffer to writeback and out

endpackage

`default_nettype wire

//--- verification/tb_ooo_core.sv
`default_nettype none

module tb_ooo_core import rob_pkg::*; ();

    localparam int ROB_DEPTH  = 8;
    localparam int MAX_CYCLES = 4000;             // Roughly 250 instructions plus drains fit well below

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    instr_t    in_instr;
    logic      squash_valid;
    rob_tag_t  squash_tag;
    reg_addr_t rd_addr;
    logic      commit_valid;
    commit_t   commit;
    data_t     rd_data;

    commit_t   exp_q [$];                         // Outstanding commits in program order
    commit_t   head_exp;
    data_t     model_regs [32];                   // Reference register file
    int        next_tag;                          // Next tag the buffer hands out
    rob_tag_t  last_tag;                          // Tag of the newest accepted instruction
    int        cycles;
    int        commits;
    int        checks;
    int        errors;
    int        stalls;                            // Negedges with in_valid high and in_ready low
    int        stall_commits;                     // Commits seen at the first stall

    ooo_core_top #(.ROB_DEPTH(ROB_DEPTH)) dut0 (
        .clk, .rst, .in_valid, .in_instr, .squash_valid, .squash_tag, .rd_addr,
        .in_ready, .commit_valid, .commit, .rd_data);

    always #50 clk = ~clk;                        // Period 100

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input longint actual, input longint expected, input string what);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Commit outputs are registered, so the low clock phase sees them stable
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A commit with tag %0d arrived with nothing outstanding", commit.tag);
            end else begin
                head_exp = exp_q.pop_front();
                check(commit.tag, head_exp.tag, "commit tag");
                check(commit.rd, head_exp.rd, "commit rd");
                check(commit.value, head_exp.value, "commit value");
                model_regs[head_exp.rd] = head_exp.value; // Retired state
                commits++;
            end
        end
    end

    function automatic data_t result_of(input instr_t ins);
        case (ins.op)
            OP_ADD:  return ins.a + ins.b;
            OP_SUB:  return ins.a - ins.b;
            OP_XOR:  return ins.a ^ ins.b;
            OP_AND:  return ins.a & ins.b;
            default: return ins.a * ins.b;        // Low 32 bits of the product
        endcase
    endfunction

    function automatic instr_t make_instr(input bit mul);
        instr_t ins;
        ins.op = mul ? OP_MUL : op_e'($urandom_range(0, 3));
        ins.rd = reg_addr_t'($urandom_range(0, 31));
        ins.a  = $urandom;
        ins.b  = $urandom;
        return ins;
    endfunction

    // Holds the instruction until in_ready shows the transfer on the next rising edge
    task automatic send(input instr_t ins);
        commit_t ent;
        bit      done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            in_valid     = 1'b1;
            in_instr     = ins;
            squash_valid = 1'b0;
            #1;
            if (in_ready) begin
                done      = 1'b1;
                ent.rd    = ins.rd;
                ent.value = result_of(ins);
                ent.tag   = rob_tag_t'(next_tag);
                exp_q.push_back(ent);
                last_tag  = ent.tag;
                next_tag  = (next_tag + 1) % ROB_DEPTH; // Sequential tags wrap
            end else begin
                if (stalls == 0) stall_commits = commits;
                stalls++;
            end
        end
    endtask

    // Drop the newest entries behind tag and restart allocation at tag plus one
    task automatic squash(input rob_tag_t tag, input int drop);
        @(negedge clk);
        in_valid     = 1'b0;
        squash_valid = 1'b1;
        squash_tag   = tag;
        for (int k = 0; k < drop; k++) void'(exp_q.pop_back());
        next_tag = (int'(tag) + 1) % ROB_DEPTH;
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid     = 1'b0;
        squash_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);                // Stray commits would show up here
    endtask

    task automatic check_regs();
        @(negedge clk);
        for (int r = 0; r < 32; r++) begin
            rd_addr = reg_addr_t'(r);
            #1;
            check(rd_data, model_regs[r], $sformatf("register %0d", r));
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        check(in_ready, 1, "in_ready after reset");
        check(commit_valid, 0, "commit_valid after reset");
        check_regs();
        report_test("reset_state");
    endtask

    task automatic stream_alu_ops();
        for (int i = 0; i < 24; i++) send(make_instr(1'b0));
        drain();
        check_regs();
        report_test("alu_stream");
    endtask

    task automatic mul_then_alu();
        send(make_instr(1'b1));                   // Slow op ahead of fast ones
        for (int i = 0; i < 4; i++) send(make_instr(1'b0));
        drain();
        check_regs();
        report_test("mul_ordering");
    endtask

    // Zero-drop squashes at the newest tag stall retirement, so the buffer fills
    task automatic fill_until_stall();
        int base;
        int first_stall;
        base        = commits;
        stalls      = 0;
        first_stall = -1;
        for (int i = 0; i < ROB_DEPTH + 4; i++) begin
            send(make_instr(i == 0));
            if (stalls != 0 && first_stall < 0) first_stall = i;
            if (i < ROB_DEPTH - 1) squash(last_tag, 0);
        end
        drain();
        check(first_stall, ROB_DEPTH, "accepted before in_ready fell");
        check(stall_commits - base, 0, "commits before the stall");
        check_regs();
        report_test("credit_stall");
    endtask

    task automatic squash_inflight_muls();
        instr_t   ins;
        rob_tag_t keep;
        for (int i = 0; i < 4; i++) begin
            ins    = make_instr(1'b1);
            ins.rd = reg_addr_t'(20 + i);          // Squashed ones target 22 and 23
            send(ins);
            if (i == 1) keep = last_tag;
        end
        squash(keep, 2);                          // Younger muls still in the pipeline
        for (int i = 0; i < 3; i++) begin
            ins    = make_instr(1'b0);
            ins.rd = reg_addr_t'(24 + i);          // Commit tags restart at keep plus one
            send(ins);
        end
        drain();
        check_regs();
        report_test("squash_muls");
    endtask

    task automatic random_with_squashes();
        int       mark;
        int       drop;
        rob_tag_t tag;
        for (int i = 0; i < 160; i++) begin
            if ($urandom_range(0, 5) == 0) begin
                send(make_instr(1'b1));
                tag  = last_tag;
                mark = cycles;
                drop = $urandom_range(0, 2);
                for (int j = 0; j < drop; j++) send(make_instr(1'b0));
                if (cycles - mark <= 2) squash(tag, drop); // Mul cannot have retired yet
            end else begin
                send(make_instr($urandom_range(0, 3) == 0));
            end
        end
        drain();
        check_regs();
        report_test("random_squash");
    endtask

    initial begin
        void'($urandom(38600));
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        squash_valid = 1'b0;
        squash_tag   = '0;
        rd_addr      = '0;
        next_tag     = 0;
        last_tag     = '0;
        cycles       = 0;
        commits      = 0;
        checks       = 0;
        errors       = 0;
        stalls       = 0;
        stall_commits = 0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        verify_reset_state();
        stream_alu_ops();
        mul_then_alu();
        fill_until_stall();
        squash_inflight_muls();
        random_with_squashes();
        $display("Checks %0d, errors %0d, commits %0d", checks, errors, commits);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
